//--- hw/spmx_pkg.sv
package spmx_pkg;

	// Machine models
	typedef enum logic [1:0] {
		MODEL_ORIGINAL = 2'd0,
		MODEL_MX_DISK  = 2'd1,
		MODEL_MX       = 2'd2
	} model_e;

	localparam int ADDR_W     = 16;
	localparam int RAM_ADDR_W = 19;
	localparam int RAM_BYTES  = 393216;
	localparam int PAGE_W     = 4;

	localparam logic [PAGE_W-1:0] ROM_PAGE = 4'd1;

	// Monitor banks in 4 KiB units
	localparam logic [7:0] MON_ORIGINAL    = 8'h1C;
	localparam logic [7:0] MON_MX          = 8'h1D;
	localparam logic [7:0] MON_MX_DISK_ALT = 8'h0C;

	localparam logic [7:0] PALETTE_RESET = 8'hF0;
	localparam logic [7:0] JMP_OPCODE    = 8'hC3;

	// Erase walk, skips the ROM page
	localparam logic [RAM_ADDR_W-1:0] ERASE_START = 19'h1FFFF;
	localparam logic [RAM_ADDR_W-1:0] ERASE_MASK  = 19'h7FFFF;
	localparam logic [RAM_ADDR_W-1:0] ERASE_END   = 19'h10000;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        wdata;
		logic              wr_n;
		logic              rd;
	} cpu_bus_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            data;
		logic                  we;
	} fill_port_t;

	typedef struct packed {
		logic ppi1;
		logic ppi2;
		logic pit;
		logic page;
		logic palette;
		logic base;
	} dev_sel_t;

	typedef struct packed {
		logic       mx;
		logic       mxd;
		logic [7:0] mon;
	} mode_t;

endpackage

//--- hw/clock_enables.sv
`timescale 1ns/1ns

module clock_enables #(
	parameter int CPU_DIV = 48
) (
	input  logic clk_sys,
	input  logic turbo_i,
	output logic ce_f1_o,
	output logic ce_f2_o,
	output logic ce_pit_o,
	output logic ce_pix_p_o,
	output logic ce_pix_n_o
);
	localparam int PH_W    = $clog2(CPU_DIV);
	localparam int PIX_DIV = 12;

	logic [3:0]      pix_cnt = '0;
	logic [PH_W-1:0] phase   = '0;
	logic            turbo   = 1'b0;

	// 16 MHz pixel enables, half a period apart
	always_ff @(posedge clk_sys) begin
		if (pix_cnt == 4'(PIX_DIV - 1)) begin
			pix_cnt <= '0;
		end else begin
			pix_cnt <= pix_cnt + 4'd1;
		end
		ce_pix_p_o <= (pix_cnt == 4'd0);
		ce_pix_n_o <= (pix_cnt == 4'(PIX_DIV / 2));
	end

	// CPU phases, turbo only switches at the wrap
	always_ff @(posedge clk_sys) begin
		if (phase == PH_W'(CPU_DIV - 1)) begin
			phase <= '0;
			turbo <= turbo_i;
		end else begin
			phase <= phase + PH_W'(1);
		end
		ce_f1_o  <= (phase == '0) | (turbo & (phase == PH_W'(CPU_DIV / 2)));
		ce_f2_o  <= (phase == PH_W'(CPU_DIV / 4)) | (turbo & (phase == PH_W'(3 * CPU_DIV / 4)));
		ce_pit_o <= (phase == '0);
	end

endmodule

//--- hw/model_reset.sv
`timescale 1ns/1ns

module model_reset (
	input  logic             clk_sys,
	input  logic             reset_i,
	input  logic             cold_reset_i,
	input  logic             key_reset_i,
	input  logic             key_alt_i,
	input  logic             erasing_i,
	input  spmx_pkg::model_e model_i,
	output logic             sys_reset_o,
	output spmx_pkg::mode_t  mode_o
);
	import spmx_pkg::*;

	logic sys_ready;
	logic cold_q;
	logic hold;

	assign hold = reset_i | ~sys_ready | key_reset_i | erasing_i;

	// Ready after the first release of the cold reset
	always_ff @(posedge clk_sys) begin
		cold_q <= cold_reset_i;
		if (reset_i) begin
			sys_ready <= 1'b0;
		end else if (cold_q & ~cold_reset_i) begin
			sys_ready <= 1'b1;
		end
	end

	// Model is only sampled while the machine sits in reset
	always_ff @(posedge clk_sys) begin
		if (hold) begin
			sys_reset_o <= 1'b1;
			mode_o.mx   <= (model_i != MODEL_ORIGINAL);
			mode_o.mxd  <= (model_i == MODEL_MX_DISK) & ~key_alt_i;
			if (model_i == MODEL_ORIGINAL) begin
				mode_o.mon <= MON_ORIGINAL;
			end else if ((model_i == MODEL_MX_DISK) && key_alt_i) begin
				// Alt boot into the diskless monitor
				mode_o.mon <= MON_MX_DISK_ALT;
			end else begin
				mode_o.mon <= MON_MX;
			end
		end else begin
			sys_reset_o <= 1'b0;
		end
	end

endmodule

//--- hw/address_decoder.sv
`timescale 1ns/1ns

module address_decoder (
	input  spmx_pkg::cpu_bus_t cpu_bus_i,
	input  spmx_pkg::mode_t    mode_i,
	input  logic               romp_i,
	input  logic [7:0]         ram_rdata_i,
	input  logic [7:0]         dev_rdata_i,
	output spmx_pkg::dev_sel_t sel_o,
	output logic               rom_sel_o,
	output logic [7:0]         cpu_din_o
);
	import spmx_pkg::*;

	typedef enum logic [3:0] {
		WIN_RAM,
		WIN_ROM,
		WIN_BASE,
		WIN_PPI1,
		WIN_PPI2,
		WIN_PIT,
		WIN_PAL,
		WIN_PAGE,
		WIN_FF
	} win_e;

	win_e              win;
	logic [ADDR_W+2:0] key;

	assign key = {mode_i.mx, mode_i.mxd, romp_i, cpu_bus_i.addr};

	// --------------------------------------
	// Window table, first match wins
	// --------------------------------------
	always_comb begin
		casez (key)
			// MX with disk, ROM page active
			19'b11_1_0???_????_????_????: win = WIN_ROM;
			19'b11_1_10??_????_????_????: win = WIN_ROM;
			// MX without disk
			19'b10_1_0000_????_????_????: win = WIN_ROM;
			19'b10_?_1100_????_????_????: win = WIN_ROM;
			// MX device area at FFC0
			19'b1?_?_1111_1111_110?_????: win = WIN_BASE;
			19'b1?_?_1111_1111_1110_00??: win = WIN_PPI1;
			19'b1?_?_1111_1111_1110_01??: win = WIN_PPI2;
			19'b1?_?_1111_1111_1110_11??: win = WIN_PIT;
			19'b1?_?_1111_1111_1111_10??: win = WIN_PAL;
			19'b1?_?_1111_1111_1111_11??: win = WIN_PAGE;
			// Floppy registers and the empty slot
			19'b1?_?_1111_1111_1110_10??,
			19'b1?_?_1111_1111_1111_0???: win = WIN_FF;
			// Original
			19'b0?_1_0000_????_????_????: win = WIN_ROM;
			19'b0?_?_1100_????_????_????: win = WIN_ROM;
			19'b0?_?_1111_0???_????_????: win = WIN_PPI2;
			19'b0?_?_1111_1???_????_????: win = WIN_PPI1;
			default: win = WIN_RAM;
		endcase
	end

	// Selects and read byte
	always_comb begin
		sel_o.ppi1    = (win == WIN_PPI1);
		sel_o.ppi2    = (win == WIN_PPI2);
		sel_o.pit     = (win == WIN_PIT);
		sel_o.palette = (win == WIN_PAL);
		sel_o.page    = (win == WIN_PAGE);
		// Plain RAM is direct mapped while the ROM page is active
		sel_o.base    = (win == WIN_BASE) | ((win == WIN_RAM) & romp_i);
		rom_sel_o     = (win == WIN_ROM);
		case (win)
			WIN_RAM, WIN_ROM, WIN_BASE: cpu_din_o = ram_rdata_i;
			WIN_PPI1, WIN_PPI2, WIN_PIT: cpu_din_o = dev_rdata_i;
			default: cpu_din_o = 8'hFF;
		endcase
	end

endmodule

//--- hw/mx_control_ports.sv
`timescale 1ns/1ns

module mx_control_ports (
	input  logic                            clk_sys,
	input  logic                            reset_i,
	input  logic                            load_i,
	input  spmx_pkg::cpu_bus_t              cpu_bus_i,
	input  spmx_pkg::mode_t                 mode_i,
	input  spmx_pkg::dev_sel_t              sel_i,
	input  logic                            rom_sel_i,
	output logic                            romp_o,
	output logic [7:0]                      palette_o,
	output logic [spmx_pkg::RAM_ADDR_W-1:0] ram_addr_o,
	output logic                            ram_we_o
);
	import spmx_pkg::*;

	logic [PAGE_W-1:0] page;
	logic              wr_n_q;
	logic              wr_fall;

	assign wr_fall = wr_n_q & ~cpu_bus_i.wr_n;
	assign romp_o  = (page == ROM_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			wr_n_q <= 1'b1;
		end else begin
			wr_n_q <= cpu_bus_i.wr_n;
		end
	end

	// --------------------------------------
	// Page register
	// --------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			page <= ROM_PAGE;
		end else if (load_i) begin
			page <= '0;
		end else begin
			if (wr_fall & sel_i.page & mode_i.mxd) begin
				case (cpu_bus_i.addr[1:0])
					2'b00: page <= '0;
					2'b01: page <= PAGE_W'(2) + PAGE_W'(cpu_bus_i.wdata[2:0]);
					default: page <= ROM_PAGE;
				endcase
			end
			// Upper half fetch drops back to page 0
			if (~(mode_i.mx & mode_i.mxd) & cpu_bus_i.addr[15]) begin
				page <= '0;
			end
		end
	end

	// Palette register
	always_ff @(posedge clk_sys) begin
		if (reset_i | load_i) begin
			palette_o <= PALETTE_RESET;
		end else if (wr_fall & sel_i.palette) begin
			palette_o <= cpu_bus_i.wdata;
		end
	end

	// --------------------------------------
	// RAM address mapping
	// --------------------------------------
	always_comb begin
		if (mode_i.mxd && !sel_i.base) begin
			ram_addr_o = RAM_ADDR_W'({page, cpu_bus_i.addr});
		end else if (!mode_i.mxd && rom_sel_i) begin
			ram_addr_o = RAM_ADDR_W'({mode_i.mon, cpu_bus_i.addr[11:0]});
		end else begin
			ram_addr_o = RAM_ADDR_W'(cpu_bus_i.addr);
		end
	end

	assign ram_we_o = ~cpu_bus_i.wr_n & ~rom_sel_i;

endmodule

//--- hw/system_ram.sv
`timescale 1ns/1ns

module system_ram (
	input  logic                            clk_sys,
	input  spmx_pkg::fill_port_t            fill_i,
	input  logic [spmx_pkg::RAM_ADDR_W-1:0] cpu_addr_i,
	input  logic [7:0]                      cpu_data_i,
	input  logic                            cpu_we_i,
	output logic [7:0]                      cpu_rdata_o
);
	import spmx_pkg::*;

	localparam logic [RAM_ADDR_W-1:0] RAM_TOP = RAM_ADDR_W'(RAM_BYTES);

	logic [7:0]            mem [RAM_BYTES];
	logic [RAM_ADDR_W-1:0] rd_addr;
	logic                  fill_ok;
	logic                  cpu_ok;

	// Page 1 holds the monitor images, the loader never touches it
	assign fill_ok = fill_i.we && (fill_i.addr[18:16] != 3'd1) && (fill_i.addr < RAM_TOP);
	assign cpu_ok  = cpu_we_i && (cpu_addr_i < RAM_TOP);

	always_ff @(posedge clk_sys) begin
		if (fill_ok) begin
			mem[fill_i.addr] <= fill_i.data;
		end
		if (cpu_ok) begin
			mem[cpu_addr_i] <= cpu_data_i;
		end
		rd_addr <= cpu_addr_i;
	end

	assign cpu_rdata_o = (rd_addr < RAM_TOP) ? mem[rd_addr] : 8'hFF;

endmodule

//--- hw/tape_loader.sv
`timescale 1ns/1ns

module tape_loader #(
	parameter int ERASE_DIV_W = 6
) (
	input  logic                 clk_sys,
	input  logic                 force_erase_i,
	input  logic                 dl_active_i,
	input  logic [7:0]           dl_index_i,
	input  logic                 dl_wr_i,
	input  logic [24:0]          dl_addr_i,
	input  logic [7:0]           dl_data_i,
	output spmx_pkg::fill_port_t fill_o,
	output logic                 erasing_o
);
	import spmx_pkg::*;

	fill_port_t             stage;
	logic [15:0]            start_addr;
	logic [15:0]            body_addr;
	logic [RAM_ADDR_W-1:0]  erase_addr;
	logic [RAM_ADDR_W-1:0]  erase_next;
	logic [ERASE_DIV_W-1:0] erase_div;
	logic                   force_q = 1'b0;
	logic                   erasing = 1'b0;

	assign erase_next = (erase_addr + RAM_ADDR_W'(1)) & ERASE_MASK;
	assign erasing_o  = erasing;

	always_ff @(posedge clk_sys) begin
		stage.we <= 1'b0;
		fill_o   <= stage;

		if (dl_active_i) begin
			erasing <= 1'b0;
			if (dl_wr_i && (dl_index_i != 8'd0)) begin
				// --------------------------------------
				// Tape image, header then body
				// --------------------------------------
				case (dl_addr_i)
					25'd0: begin
						start_addr[7:0] <= dl_data_i;
						stage.addr      <= '0;
						stage.data      <= JMP_OPCODE;
						stage.we        <= 1'b1;
					end
					25'd1: begin
						start_addr[15:8] <= dl_data_i;
						stage.addr       <= RAM_ADDR_W'(1);
						stage.data       <= start_addr[7:0];
						stage.we         <= 1'b1;
					end
					25'd2: begin
						stage.addr <= RAM_ADDR_W'(2);
						stage.data <= start_addr[15:8];
						stage.we   <= 1'b1;
					end
					// End address byte, not needed
					25'd3: begin
						body_addr <= start_addr;
					end
					default: begin
						stage.addr <= RAM_ADDR_W'(body_addr);
						stage.data <= dl_data_i;
						stage.we   <= 1'b1;
						body_addr  <= body_addr + 16'd1;
					end
				endcase
			end
		end else begin
			force_q <= force_erase_i;
			if (force_erase_i & ~force_q) begin
				erase_addr <= ERASE_START;
				erase_div  <= ERASE_DIV_W'(1);
				erasing    <= 1'b1;
			end else if (erasing) begin
				// One zero byte per divider wrap
				erase_div <= erase_div + ERASE_DIV_W'(1);
				if (erase_div == '0) begin
					if (erase_next == ERASE_END) begin
						erasing <= 1'b0;
					end else begin
						erase_addr <= erase_next;
						stage.addr <= erase_next;
						stage.data <= 8'h00;
						stage.we   <= 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- hw/spmx_core.sv
`timescale 1ns/1ns

module spmx_core #(
	parameter int ERASE_DIV_W = 6,
	parameter int CPU_DIV     = 48
) (
	input  logic               clk_sys,
	input  logic               reset_i,
	input  spmx_pkg::cpu_bus_t cpu_bus_i,
	input  logic [7:0]         dev_rdata_i,
	input  spmx_pkg::model_e   model_i,
	input  logic               turbo_i,
	input  logic               cold_reset_i,
	input  logic               key_reset_i,
	input  logic               key_alt_i,
	input  logic               force_erase_i,
	input  logic               dl_active_i,
	input  logic [7:0]         dl_index_i,
	input  logic               dl_wr_i,
	input  logic [24:0]        dl_addr_i,
	input  logic [7:0]         dl_data_i,
	output logic [7:0]         cpu_din_o,
	output logic               cpu_reset_o,
	output logic               ce_f1_o,
	output logic               ce_f2_o,
	output logic               ce_pit_o,
	output logic               ce_pix_p_o,
	output logic               ce_pix_n_o,
	output spmx_pkg::dev_sel_t dev_sel_o,
	output logic [7:0]         palette_o,
	output logic               filling_o
);
	import spmx_pkg::*;

	logic                  sys_reset;
	mode_t                 mode;
	logic                  romp;
	logic                  rom_sel;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_we;
	logic [7:0]            ram_rdata;
	fill_port_t            fill;
	logic                  erasing;
	logic                  tape_load;

	// CPU stays in reset for the whole tape load
	assign tape_load   = dl_active_i & (dl_index_i != 8'd0);
	assign cpu_reset_o = sys_reset | tape_load;
	assign filling_o   = dl_active_i | erasing;

	clock_enables #(.CPU_DIV(CPU_DIV)) u_clock_enables (
		.clk_sys   (clk_sys),
		.turbo_i   (turbo_i),
		.ce_f1_o   (ce_f1_o),
		.ce_f2_o   (ce_f2_o),
		.ce_pit_o  (ce_pit_o),
		.ce_pix_p_o(ce_pix_p_o),
		.ce_pix_n_o(ce_pix_n_o)
	);

	model_reset u_model_reset (
		.clk_sys     (clk_sys),
		.reset_i     (reset_i),
		.cold_reset_i(cold_reset_i),
		.key_reset_i (key_reset_i),
		.key_alt_i   (key_alt_i),
		.erasing_i   (erasing),
		.model_i     (model_i),
		.sys_reset_o (sys_reset),
		.mode_o      (mode)
	);

	address_decoder u_address_decoder (
		.cpu_bus_i  (cpu_bus_i),
		.mode_i     (mode),
		.romp_i     (romp),
		.ram_rdata_i(ram_rdata),
		.dev_rdata_i(dev_rdata_i),
		.sel_o      (dev_sel_o),
		.rom_sel_o  (rom_sel),
		.cpu_din_o  (cpu_din_o)
	);

	mx_control_ports u_mx_control_ports (
		.clk_sys   (clk_sys),
		.reset_i   (sys_reset),
		.load_i    (tape_load),
		.cpu_bus_i (cpu_bus_i),
		.mode_i    (mode),
		.sel_i     (dev_sel_o),
		.rom_sel_i (rom_sel),
		.romp_o    (romp),
		.palette_o (palette_o),
		.ram_addr_o(ram_addr),
		.ram_we_o  (ram_we)
	);

	system_ram u_system_ram (
		.clk_sys    (clk_sys),
		.fill_i     (fill),
		.cpu_addr_i (ram_addr),
		.cpu_data_i (cpu_bus_i.wdata),
		.cpu_we_i   (ram_we),
		.cpu_rdata_o(ram_rdata)
	);

	tape_loader #(.ERASE_DIV_W(ERASE_DIV_W)) u_tape_loader (
		.clk_sys      (clk_sys),
		.force_erase_i(force_erase_i),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_index_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.fill_o       (fill),
		.erasing_o    (erasing)
	);

endmodule

//--- tests/tb_spmx.sv
`timescale 1ns/1ns

module tb_spmx;
	import spmx_pkg::*;

	// Fast erase pacing keeps the full RAM walk short
	localparam int ERASE_DIV_W    = 2;
	localparam int CPU_DIV        = 48;
	// Erase walks 20000..7FFFF, then 00000..0FFFF
	localparam int ERASE_CYCLES   = 32'h70000 << ERASE_DIV_W;
	localparam int TIMEOUT_CYCLES = ERASE_CYCLES + 20000;

	logic        clk_sys;
	logic        reset_i;
	cpu_bus_t    cpu_bus;
	logic [7:0]  dev_rdata;
	model_e      model;
	logic        turbo;
	logic        cold_reset;
	logic        key_reset;
	logic        key_alt;
	logic        force_erase;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic [7:0]  cpu_din;
	logic        cpu_reset;
	logic        ce_f1;
	logic        ce_f2;
	logic        ce_pit;
	logic        ce_pix_p;
	logic        ce_pix_n;
	dev_sel_t    dev_sel;
	logic [7:0]  palette;
	logic        filling;

	int         errors;
	int         checks;
	int         cycles;
	logic [7:0] body [8];

	spmx_core #(.ERASE_DIV_W(ERASE_DIV_W), .CPU_DIV(CPU_DIV)) i_dut (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.cpu_bus_i    (cpu_bus),
		.dev_rdata_i  (dev_rdata),
		.model_i      (model),
		.turbo_i      (turbo),
		.cold_reset_i (cold_reset),
		.key_reset_i  (key_reset),
		.key_alt_i    (key_alt),
		.force_erase_i(force_erase),
		.dl_active_i  (dl_active),
		.dl_index_i   (dl_index),
		.dl_wr_i      (dl_wr),
		.dl_addr_i    (dl_addr),
		.dl_data_i    (dl_data),
		.cpu_din_o    (cpu_din),
		.cpu_reset_o  (cpu_reset),
		.ce_f1_o      (ce_f1),
		.ce_f2_o      (ce_f2),
		.ce_pit_o     (ce_pit),
		.ce_pix_p_o   (ce_pix_p),
		.ce_pix_n_o   (ce_pix_n),
		.dev_sel_o    (dev_sel),
		.palette_o    (palette),
		.filling_o    (filling)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// --------------------------------------
	// Helpers
	// --------------------------------------
	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic step_n(input int n);
		repeat (n) step();
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("error %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Key reset relatches the model
	task automatic restart(input model_e m);
		step();
		cpu_bus.addr = 16'h0000;
		model        = m;
		key_reset    = 1'b1;
		step_n(4);
		key_reset = 1'b0;
		step_n(3);
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		step();
		cpu_bus.rd    = 1'b0;
		cpu_bus.addr  = a;
		cpu_bus.wdata = d;
		cpu_bus.wr_n  = 1'b0;
		step_n(2);
		cpu_bus.wr_n = 1'b1;
		step();
	endtask

	// RAM data is valid one edge after the address
	task automatic read_expect(input string name, input logic [15:0] a, input logic [7:0] exp);
		step();
		cpu_bus.addr = a;
		cpu_bus.rd   = 1'b1;
		step_n(2);
		@(negedge clk_sys);
		check_byte(name, exp, cpu_din);
	endtask

	task automatic probe(input logic [15:0] a);
		step();
		cpu_bus.addr = a;
		@(negedge clk_sys);
	endtask

	task automatic count_enables(output int n_f1, output int n_f2, output int n_pit,
			output int n_pp, output int n_pn);
		n_f1  = 0;
		n_f2  = 0;
		n_pit = 0;
		n_pp  = 0;
		n_pn  = 0;
		repeat (480) begin
			@(negedge clk_sys);
			n_f1  += int'(ce_f1);
			n_f2  += int'(ce_f2);
			n_pit += int'(ce_pit);
			n_pp  += int'(ce_pix_p);
			n_pn  += int'(ce_pix_n);
		end
		step();
	endtask

	// --------------------------------------
	// Tests
	// --------------------------------------
	task automatic test_clock_enables();
		int n_f1;
		int n_f2;
		int n_pit;
		int n_pp;
		int n_pn;
		count_enables(n_f1, n_f2, n_pit, n_pp, n_pn);
		check_count("test_clock_enables f1", 10, n_f1);
		check_count("test_clock_enables f2", 10, n_f2);
		check_count("test_clock_enables pit", 10, n_pit);
		check_count("test_clock_enables pix_p", 40, n_pp);
		check_count("test_clock_enables pix_n", 40, n_pn);
		turbo = 1'b1;
		// Turbo switches at the divider wrap
		step_n(2 * CPU_DIV);
		count_enables(n_f1, n_f2, n_pit, n_pp, n_pn);
		check_count("test_clock_enables turbo f1", 20, n_f1);
		check_count("test_clock_enables turbo f2", 20, n_f2);
		check_count("test_clock_enables turbo pit", 10, n_pit);
		turbo = 1'b0;
		step_n(2 * CPU_DIV);
	endtask

	task automatic test_tape_load();
		logic [7:0] hdr [4];
		hdr = '{8'h23, 8'h01, 8'h2A, 8'h01};
		restart(MODEL_MX_DISK);
		dl_index  = 8'd1;
		dl_active = 1'b1;
		step();
		for (int i = 0; i < 12; i++) begin
			dl_addr = 25'(i);
			if (i < 4) begin
				dl_data = hdr[i];
			end else begin
				dl_data = body[i - 4];
			end
			dl_wr = 1'b1;
			step();
			dl_wr = 1'b0;
			step_n(2);
		end
		check_bit("test_tape_load cpu_reset", 1'b1, cpu_reset);
		step_n(4);
		dl_active = 1'b0;
		dl_index  = 8'd0;
		step_n(4);
		read_expect("test_tape_load jmp", 16'h0000, 8'hC3);
		read_expect("test_tape_load start lo", 16'h0001, 8'h23);
		read_expect("test_tape_load start hi", 16'h0002, 8'h01);
		for (int i = 0; i < 8; i++) begin
			read_expect("test_tape_load body", 16'h0123 + 16'(i), body[i]);
		end
	endtask

	task automatic test_decoder();
		restart(MODEL_ORIGINAL);
		dev_rdata = 8'h5A;
		probe(16'hF800);
		check_bit("test_decoder ppi1", 1'b1, dev_sel.ppi1);
		check_bit("test_decoder ppi2 idle", 1'b0, dev_sel.ppi2);
		check_byte("test_decoder ppi1 data", 8'h5A, cpu_din);
		probe(16'hF000);
		check_bit("test_decoder ppi2", 1'b1, dev_sel.ppi2);
		restart(MODEL_MX);
		probe(16'hFFEC);
		check_bit("test_decoder pit", 1'b1, dev_sel.pit);
		check_byte("test_decoder pit data", 8'h5A, cpu_din);
		probe(16'hFFE8);
		check_bit("test_decoder floppy pit", 1'b0, dev_sel.pit);
		check_byte("test_decoder floppy data", 8'hFF, cpu_din);
		probe(16'hFFF8);
		check_bit("test_decoder palette", 1'b1, dev_sel.palette);
		probe(16'hFFFC);
		check_bit("test_decoder page", 1'b1, dev_sel.page);
	endtask

	task automatic test_palette_page();
		restart(MODEL_MX_DISK);
		check_byte("test_palette_page reset", 8'hF0, palette);
		cpu_write(16'hFFF8, 8'h3C);
		check_byte("test_palette_page write", 8'h3C, palette);
		// Page 2 + 3
		cpu_write(16'hFFFD, 8'h03);
		cpu_write(16'h0100, 8'hA5);
		read_expect("test_palette_page ram", 16'h0100, 8'hA5);
		// Same CPU address in page 0 is another byte
		cpu_write(16'hFFFC, 8'h00);
		cpu_write(16'h0100, 8'h5A);
		read_expect("test_palette_page page 0", 16'h0100, 8'h5A);
		cpu_write(16'hFFFD, 8'h03);
		read_expect("test_palette_page page 5", 16'h0100, 8'hA5);
	endtask

	task automatic test_erase();
		int waited;
		step();
		force_erase = 1'b1;
		step_n(2);
		check_bit("test_erase filling", 1'b1, filling);
		force_erase = 1'b0;
		waited      = 0;
		while (filling && (waited < ERASE_CYCLES + 1000)) begin
			step();
			waited++;
		end
		checks++;
		assert (!filling) else begin
			errors++;
			$display("test_erase: filling_o still high after %0d cycles", waited);
		end
		step_n(3);
		check_byte("test_erase palette", 8'hF0, palette);
		cpu_write(16'hFFFC, 8'h00);
		read_expect("test_erase jmp", 16'h0000, 8'h00);
		read_expect("test_erase start lo", 16'h0001, 8'h00);
		read_expect("test_erase start hi", 16'h0002, 8'h00);
		for (int i = 0; i < 8; i++) begin
			read_expect("test_erase body", 16'h0123 + 16'(i), 8'h00);
		end
		cpu_write(16'hFFFD, 8'h03);
		read_expect("test_erase page 5", 16'h0100, 8'h00);
	endtask

	// --------------------------------------
	// Main sequence
	// --------------------------------------
	initial begin
		errors        = 0;
		checks        = 0;
		reset_i       = 1'b1;
		cpu_bus.addr  = 16'h0000;
		cpu_bus.wdata = 8'h00;
		cpu_bus.wr_n  = 1'b1;
		cpu_bus.rd    = 1'b0;
		dev_rdata     = 8'h00;
		model         = MODEL_MX_DISK;
		turbo         = 1'b0;
		cold_reset    = 1'b1;
		key_reset     = 1'b0;
		key_alt       = 1'b0;
		force_erase   = 1'b0;
		dl_active     = 1'b0;
		dl_index      = 8'd0;
		dl_wr         = 1'b0;
		dl_addr       = 25'd0;
		dl_data       = 8'h00;
		body          = '{8'h3E, 8'h55, 8'hCD, 8'h81, 8'h12, 8'hFF, 8'hA7, 8'h69};
		step_n(16);
		reset_i = 1'b0;
		step_n(2);
		// Machine leaves reset on the cold reset release
		cold_reset = 1'b0;
		step_n(4);
		check_bit("startup cpu_reset", 1'b0, cpu_reset);

		test_clock_enables();
		test_tape_load();
		test_decoder();
		test_palette_page();
		test_erase();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("timeout: run stopped after %0d clock cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

//--- files.f
hw/spmx_pkg.sv
hw/clock_enables.sv
hw/model_reset.sv
hw/address_decoder.sv
hw/mx_control_ports.sv
hw/system_ram.sv
hw/tape_loader.sv
hw/spmx_core.sv
tests/tb_spmx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_spmx -Mdir obj_dir -o Vtb_spmx -f files.f
./obj_dir/Vtb_spmx > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
exit 0
